// File: source/alu_pkg.sv
package alu_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_LANES     = 4;
    localparam int NUM_WARPS     = 8;
    localparam int UUID_BITS     = 8;
    localparam int NUM_REGS_BITS = 5;
    localparam int WID_BITS      = $clog2(NUM_WARPS);

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [WID_BITS-1:0]      warp_id_t;
    typedef logic [NUM_LANES-1:0]     tmask_t;
    typedef logic [UUID_BITS-1:0]     uuid_t;
    typedef logic [NUM_REGS_BITS-1:0] reg_id_t;

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        BEQ, BNE, BLT, BGE,
        MUL, MULH, MULHU, DIV, DIVU, REM, REMU
    } alu_op_t;

    typedef struct packed {
        uuid_t                     uuid;
        warp_id_t                  wid;
        tmask_t                    tmask;
        word_t                     pc;
        alu_op_t                   op;
        reg_id_t                   rd;
        logic                      wb;
        word_t [NUM_LANES-1:0]     rs1_data;
        word_t [NUM_LANES-1:0]     rs2_data;
        word_t                     imm;
    } dispatch_t;

    typedef struct packed {
        uuid_t                     uuid;
        warp_id_t                  wid;
        tmask_t                    tmask;
        word_t                     pc;
        reg_id_t                   rd;
        logic                      wb;
        word_t [NUM_LANES-1:0]     data;
    } commit_t;

    typedef struct packed {
        warp_id_t                  wid;
        logic                      taken;
        word_t                     target;
    } branch_ctl_t;

    // Opcode class used to steer an instruction to the multiply/divide unit
    function automatic logic is_muldiv_op(alu_op_t op);
        return op inside {MUL, MULH, MULHU, DIV, DIVU, REM, REMU};
    endfunction

endpackage

// File: source/int_unit.sv
`timescale 1ns/1ps

module int_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  alu_pkg::dispatch_t   in_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output alu_pkg::commit_t     out_data,
    output logic                 branch_ctl_valid,
    output alu_pkg::branch_ctl_t branch_ctl
);
    import alu_pkg::*;

    localparam int SHAMT_BITS = $clog2(XLEN);
    localparam int LANE_BITS  = $clog2(NUM_LANES);

    word_t [NUM_LANES-1:0] lane_result;
    logic [LANE_BITS-1:0]  lead_lane;
    word_t                 lead_rs1;
    word_t                 lead_rs2;
    logic                  is_branch;
    logic                  br_taken;
    logic                  fire;

    always_comb begin
        word_t a;
        word_t b;
        for (int i = 0; i < NUM_LANES; i++) begin
            a = in_data.rs1_data[i];
            b = in_data.rs2_data[i];
            case (in_data.op)
                ADD:     lane_result[i] = a + b;
                SUB:     lane_result[i] = a - b;
                AND:     lane_result[i] = a & b;
                OR:      lane_result[i] = a | b;
                XOR:     lane_result[i] = a ^ b;
                SLL:     lane_result[i] = a << b[SHAMT_BITS-1:0];
                SRL:     lane_result[i] = a >> b[SHAMT_BITS-1:0];
                SRA:     lane_result[i] = $signed(a) >>> b[SHAMT_BITS-1:0];
                SLT:     lane_result[i] = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                SLTU:    lane_result[i] = {{(XLEN-1){1'b0}}, a < b};
                BEQ, BNE, BLT, BGE: lane_result[i] = in_data.pc + word_t'(4);
                default: lane_result[i] = '0;
            endcase
            // Inactive threads write back zero
            if (!in_data.tmask[i]) begin
                lane_result[i] = '0;
            end
        end
    end

    // Lowest set mask bit wins, so scan from the top down
    always_comb begin
        lead_lane = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (in_data.tmask[i]) begin
                lead_lane = LANE_BITS'(i);
            end
        end
    end

    assign lead_rs1  = in_data.rs1_data[lead_lane];
    assign lead_rs2  = in_data.rs2_data[lead_lane];
    assign is_branch = in_data.op inside {BEQ, BNE, BLT, BGE};

    always_comb begin
        case (in_data.op)
            BEQ:     br_taken = lead_rs1 == lead_rs2;
            BNE:     br_taken = lead_rs1 != lead_rs2;
            BLT:     br_taken = $signed(lead_rs1) < $signed(lead_rs2);
            BGE:     br_taken = $signed(lead_rs1) >= $signed(lead_rs2);
            default: br_taken = 1'b0;
        endcase
    end

    assign in_ready = !out_valid || out_ready;
    assign fire     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid        <= 1'b0;
            branch_ctl_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            branch_ctl_valid <= fire && is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_data.uuid     <= in_data.uuid;
            out_data.wid      <= in_data.wid;
            out_data.tmask    <= in_data.tmask;
            out_data.pc       <= in_data.pc;
            out_data.rd       <= in_data.rd;
            out_data.wb       <= in_data.wb;
            out_data.data     <= lane_result;
            branch_ctl.wid    <= in_data.wid;
            branch_ctl.taken  <= br_taken;
            branch_ctl.target <= in_data.pc + in_data.imm;
        end
    end

endmodule

// File: source/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit #(
    parameter int MUL_LATENCY = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  alu_pkg::dispatch_t in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output alu_pkg::commit_t   out_data
);
    import alu_pkg::*;

    // The output register is the last multiply stage
    localparam int    MUL_STAGES = MUL_LATENCY - 1;
    localparam int    CNT_BITS   = $clog2(XLEN);
    localparam word_t MIN_INT    = {1'b1, {(XLEN-1){1'b0}}};

    typedef logic [2*XLEN-1:0] dword_t;
    typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_t;

    typedef struct packed {
        uuid_t    uuid;
        warp_id_t wid;
        tmask_t   tmask;
        word_t    pc;
        reg_id_t  rd;
        logic     wb;
        alu_op_t  op;
    } md_meta_t;

    typedef struct packed {
        md_meta_t                meta;
        dword_t [NUM_LANES-1:0]  prod;
    } mul_stage_t;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t den;
        word_t quo;
        word_t rem;
    } div_lane_t;

    md_meta_t                  in_meta;
    logic                      is_mul;
    logic                      out_free;
    logic                      mul_fire;
    logic                      div_fire;
    logic [MUL_STAGES-1:0]     mul_valid;
    mul_stage_t                mul_entry;
    mul_stage_t [MUL_STAGES-1:0] mul_pipe;
    word_t [NUM_LANES-1:0]     mul_result;
    div_state_t                div_state;
    logic [CNT_BITS-1:0]       div_count;
    md_meta_t                  div_meta;
    div_lane_t [NUM_LANES-1:0] div_init;
    div_lane_t [NUM_LANES-1:0] div_src;
    div_lane_t [NUM_LANES-1:0] div_next;
    div_lane_t [NUM_LANES-1:0] div_lane;
    word_t [NUM_LANES-1:0]     div_result;

    function automatic commit_t make_commit(md_meta_t m, word_t [NUM_LANES-1:0] d);
        return '{uuid: m.uuid, wid: m.wid, tmask: m.tmask, pc: m.pc,
                 rd: m.rd, wb: m.wb, data: d};
    endfunction

    assign in_meta = '{uuid: in_data.uuid, wid: in_data.wid, tmask: in_data.tmask,
                       pc: in_data.pc, rd: in_data.rd, wb: in_data.wb, op: in_data.op};

    // Multiplies and divides never overlap, so one output register serves both
    assign is_mul   = in_data.op inside {MUL, MULH, MULHU};
    assign out_free = !out_valid || out_ready;
    assign in_ready = (div_state == IDLE) && (is_mul ? out_free : (mul_valid == '0));
    assign mul_fire = in_valid && in_ready && is_mul;
    assign div_fire = in_valid && in_ready && !is_mul;

    always_comb begin
        logic signed [XLEN:0]     sa;
        logic signed [XLEN:0]     sb;
        logic signed [2*XLEN+1:0] full;
        mul_entry.meta = in_meta;
        for (int i = 0; i < NUM_LANES; i++) begin
            // MULHU zero-extends, the other multiplies sign-extend
            sa   = {in_data.op != MULHU && in_data.rs1_data[i][XLEN-1], in_data.rs1_data[i]};
            sb   = {in_data.op != MULHU && in_data.rs2_data[i][XLEN-1], in_data.rs2_data[i]};
            full = sa * sb;
            mul_entry.prod[i] = full[2*XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_valid <= '0;
        end else if (out_free) begin
            mul_valid[0] <= mul_fire;
            for (int s = 1; s < MUL_STAGES; s++) begin
                mul_valid[s] <= mul_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            mul_pipe[0] <= mul_entry;
            for (int s = 1; s < MUL_STAGES; s++) begin
                mul_pipe[s] <= mul_pipe[s-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (!mul_pipe[MUL_STAGES-1].meta.tmask[i]) begin
                mul_result[i] = '0;
            end else if (mul_pipe[MUL_STAGES-1].meta.op == MUL) begin
                mul_result[i] = mul_pipe[MUL_STAGES-1].prod[i][XLEN-1:0];
            end else begin
                mul_result[i] = mul_pipe[MUL_STAGES-1].prod[i][2*XLEN-1:XLEN];
            end
        end
    end

    // The divider works on magnitudes and does its first step on the load edge
    always_comb begin
        logic              sgn;
        logic [XLEN:0]     shifted;
        logic [XLEN:0]     diff;
        sgn = in_data.op inside {DIV, REM};
        for (int i = 0; i < NUM_LANES; i++) begin
            div_init[i].a   = in_data.rs1_data[i];
            div_init[i].b   = in_data.rs2_data[i];
            div_init[i].quo = (sgn && in_data.rs1_data[i][XLEN-1]) ?
                              -in_data.rs1_data[i] : in_data.rs1_data[i];
            div_init[i].den = (sgn && in_data.rs2_data[i][XLEN-1]) ?
                              -in_data.rs2_data[i] : in_data.rs2_data[i];
            div_init[i].rem = '0;
            div_src[i]  = (div_state == IDLE) ? div_init[i] : div_lane[i];
            div_next[i] = div_src[i];
            shifted = {div_src[i].rem, div_src[i].quo[XLEN-1]};
            diff    = shifted - {1'b0, div_src[i].den};
            if (diff[XLEN]) begin
                div_next[i].rem = shifted[XLEN-1:0];
                div_next[i].quo = {div_src[i].quo[XLEN-2:0], 1'b0};
            end else begin
                div_next[i].rem = diff[XLEN-1:0];
                div_next[i].quo = {div_src[i].quo[XLEN-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_state <= IDLE;
            div_count <= '0;
        end else begin
            case (div_state)
                IDLE: if (div_fire) begin
                    div_state <= RUN;
                    div_count <= CNT_BITS'(1);
                end
                RUN: begin
                    div_count <= div_count + 1'b1;
                    if (div_count == CNT_BITS'(XLEN - 1)) begin
                        div_state <= DONE;
                    end
                end
                DONE: if (out_free) begin
                    div_state <= IDLE;
                end
                default: div_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (div_fire) begin
            div_meta <= in_meta;
        end
        if (div_fire || div_state == RUN) begin
            div_lane <= div_next;
        end
    end

    always_comb begin
        logic  sgn;
        word_t q;
        word_t r;
        sgn = div_meta.op inside {DIV, REM};
        for (int i = 0; i < NUM_LANES; i++) begin
            q = (sgn && (div_lane[i].a[XLEN-1] ^ div_lane[i].b[XLEN-1])) ?
                -div_lane[i].quo : div_lane[i].quo;
            r = (sgn && div_lane[i].a[XLEN-1]) ? -div_lane[i].rem : div_lane[i].rem;
            if (div_lane[i].b == '0) begin
                q = '1;
                r = div_lane[i].a;
            end else if (sgn && div_lane[i].a == MIN_INT && div_lane[i].b == '1) begin
                q = div_lane[i].a;
                r = '0;
            end
            div_result[i] = (div_meta.op inside {DIV, DIVU}) ? q : r;
            if (!div_meta.tmask[i]) begin
                div_result[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_free) begin
            out_valid <= (div_state == DONE) || mul_valid[MUL_STAGES-1];
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (div_state == DONE) begin
                out_data <= make_commit(div_meta, div_result);
            end else if (mul_valid[MUL_STAGES-1]) begin
                out_data <= make_commit(mul_pipe[MUL_STAGES-1].meta, mul_result);
            end
        end
    end

endmodule

// File: source/commit_arb.sv
`timescale 1ns/1ps

module commit_arb (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             in_valid,
    output logic [1:0]             in_ready,
    input  alu_pkg::commit_t [1:0] in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output alu_pkg::commit_t       out_data
);
    import alu_pkg::*;

    logic rr_ptr;
    logic grant_idx;
    logic load;
    logic fire;

    // Pointer only matters on a tie, a lone requester always wins
    assign grant_idx = (&in_valid) ? rr_ptr : in_valid[1];
    assign load      = !out_valid || out_ready;
    assign fire      = load && (|in_valid);

    always_comb begin
        in_ready = 2'b00;
        if (load) begin
            in_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            rr_ptr    <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= |in_valid;
            end
            // Next tie goes to the input that lost this one
            if (fire) begin
                rr_ptr <= ~grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_data <= in_data[grant_idx];
        end
    end

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int MUL_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_valid,
    output logic                 dispatch_ready,
    input  alu_pkg::dispatch_t   dispatch,
    output logic                 commit_valid,
    input  logic                 commit_ready,
    output alu_pkg::commit_t     commit,
    output logic                 branch_ctl_valid,
    output alu_pkg::branch_ctl_t branch_ctl
);
    import alu_pkg::*;

    logic          is_muldiv;
    logic          int_valid;
    logic          int_ready;
    logic          mdv_valid;
    logic          mdv_ready;
    logic [1:0]    rsp_valid;
    logic [1:0]    rsp_ready;
    commit_t [1:0] rsp_data;

    // Both units see the same payload, only the valid is split by class
    assign is_muldiv      = is_muldiv_op(dispatch.op);
    assign int_valid      = dispatch_valid && !is_muldiv;
    assign mdv_valid      = dispatch_valid && is_muldiv;
    assign dispatch_ready = is_muldiv ? mdv_ready : int_ready;

    int_unit int_unit_inst (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (int_valid),
        .in_ready         (int_ready),
        .in_data          (dispatch),
        .out_valid        (rsp_valid[0]),
        .out_ready        (rsp_ready[0]),
        .out_data         (rsp_data[0]),
        .branch_ctl_valid (branch_ctl_valid),
        .branch_ctl       (branch_ctl)
    );

    muldiv_unit #(
        .MUL_LATENCY (MUL_LATENCY)
    ) muldiv_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mdv_valid),
        .in_ready  (mdv_ready),
        .in_data   (dispatch),
        .out_valid (rsp_valid[1]),
        .out_ready (rsp_ready[1]),
        .out_data  (rsp_data[1])
    );

    commit_arb commit_arb_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rsp_valid),
        .in_ready  (rsp_ready),
        .in_data   (rsp_data),
        .out_valid (commit_valid),
        .out_ready (commit_ready),
        .out_data  (commit)
    );

endmodule

// File: test/alu_unit_asserts.sv
`timescale 1ns/1ps

module alu_unit_asserts (
    input logic               clk,
    input logic               rst,
    input logic               dispatch_valid,
    input logic               dispatch_ready,
    input alu_pkg::dispatch_t dispatch,
    input logic               commit_valid,
    input logic               commit_ready,
    input alu_pkg::commit_t   commit,
    input logic               branch_ctl_valid
);
    import alu_pkg::*;

    int   fail_count = 0;
    logic seen_dispatch;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_dispatch <= 1'b0;
        end else if (dispatch_valid && dispatch_ready) begin
            seen_dispatch <= 1'b1;
        end
    end

    // A stalled commit must hold both its valid and its payload
    commit_hold: assert property (@(posedge clk) disable iff (rst)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin
            $error("commit changed while commit_ready was low");
            fail_count++;
        end

    // A branch pulse only follows a branch that the top level accepted
    branch_after_accept: assert property (@(posedge clk) disable iff (rst)
        branch_ctl_valid |-> $past(dispatch_valid && dispatch_ready &&
                                   dispatch.op inside {BEQ, BNE, BLT, BGE}))
        else begin
            $error("branch_ctl pulsed without an accepted branch dispatch");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_dispatch |-> !commit_valid && !branch_ctl_valid)
        else begin
            $error("output valid raised before any dispatch");
            fail_count++;
        end

endmodule

bind alu_unit alu_unit_asserts alu_unit_asserts_inst (
    .clk              (clk),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_ready   (dispatch_ready),
    .dispatch         (dispatch),
    .commit_valid     (commit_valid),
    .commit_ready     (commit_ready),
    .commit           (commit),
    .branch_ctl_valid (branch_ctl_valid)
);

// File: test/alu_unit_tb.sv
`timescale 1ns/1ps

module alu_unit_tb;
    import alu_pkg::*;

    localparam int    MUL_LATENCY   = 2;
    localparam int    CLK_PERIOD    = 100;
    localparam int    MAX_OPS       = 300;
    localparam int    CYCLES_PER_OP = 40;
    localparam int    RANDOM_OPS    = 200;
    localparam int    NUM_OPCODES   = 21;
    localparam word_t MIN_INT       = 32'h8000_0000;

    logic         clk;
    logic         rst;
    logic         dispatch_valid;
    logic         dispatch_ready;
    dispatch_t    dispatch;
    logic         commit_valid;
    logic         commit_ready;
    commit_t      commit;
    logic         branch_ctl_valid;
    branch_ctl_t  branch_ctl;

    int           seed;
    logic         timed;
    logic         bp_on;
    uuid_t        next_uuid;
    int           cycle;
    int           outstanding;
    int           n_commits;
    int           n_branches;
    int           err_count [4];
    logic [255:0] pending;
    commit_t      exp_commit [256];
    int           disp_cycle [256];
    int           exp_lat [256];
    branch_ctl_t  exp_branch [$];

    alu_unit #(
        .MUL_LATENCY (MUL_LATENCY)
    ) alu_unit_inst (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid   (dispatch_valid),
        .dispatch_ready   (dispatch_ready),
        .dispatch         (dispatch),
        .commit_valid     (commit_valid),
        .commit_ready     (commit_ready),
        .commit           (commit),
        .branch_ctl_valid (branch_ctl_valid),
        .branch_ctl       (branch_ctl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Operands lean toward zero, all ones and the most negative value
    function automatic word_t rand_word();
        int pick;
        pick = {$random(seed)} % 8;
        case (pick)
            0:       return '0;
            1:       return '1;
            2:       return MIN_INT;
            default: return word_t'($random(seed));
        endcase
    endfunction

    function automatic word_t divide(word_t a, word_t b, bit is_signed, bit want_rem);
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        if (is_signed && a == MIN_INT && b == '1) begin
            return want_rem ? '0 : a;
        end
        if (is_signed) begin
            if (want_rem) begin
                return $signed(a) % $signed(b);
            end
            return $signed(a) / $signed(b);
        end
        return want_rem ? a % b : a / b;
    endfunction

    function automatic word_t lane_value(alu_op_t op, word_t a, word_t b, word_t pc);
        longint      sp;
        logic [63:0] up;
        sp = longint'($signed(a)) * longint'($signed(b));
        up = {32'b0, a} * {32'b0, b};
        case (op)
            ADD:                return a + b;
            SUB:                return a - b;
            AND:                return a & b;
            OR:                 return a | b;
            XOR:                return a ^ b;
            SLL:                return a << b[4:0];
            SRL:                return a >> b[4:0];
            SRA:                return $signed(a) >>> b[4:0];
            SLT:                return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:               return (a < b) ? 32'd1 : 32'd0;
            BEQ, BNE, BLT, BGE: return pc + 32'd4;
            MUL:                return up[31:0];
            MULH:               return sp[63:32];
            MULHU:              return up[63:32];
            DIV:                return divide(a, b, 1'b1, 1'b0);
            DIVU:               return divide(a, b, 1'b0, 1'b0);
            REM:                return divide(a, b, 1'b1, 1'b1);
            REMU:               return divide(a, b, 1'b0, 1'b1);
            default:            return '0;
        endcase
    endfunction

    function automatic commit_t expected_commit(dispatch_t d);
        commit_t c;
        c.uuid  = d.uuid;
        c.wid   = d.wid;
        c.tmask = d.tmask;
        c.pc    = d.pc;
        c.rd    = d.rd;
        c.wb    = d.wb;
        for (int i = 0; i < NUM_LANES; i++) begin
            c.data[i] = d.tmask[i] ? lane_value(d.op, d.rs1_data[i], d.rs2_data[i], d.pc) : '0;
        end
        return c;
    endfunction

    // The branch is decided by the lowest lane whose mask bit is set
    function automatic branch_ctl_t expected_branch(dispatch_t d);
        branch_ctl_t b;
        int          lead;
        word_t       x;
        word_t       y;
        lead = -1;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lead < 0 && d.tmask[i]) begin
                lead = i;
            end
        end
        x = d.rs1_data[lead];
        y = d.rs2_data[lead];
        b.wid    = d.wid;
        b.target = d.pc + d.imm;
        case (d.op)
            BEQ:     b.taken = (x == y);
            BNE:     b.taken = (x != y);
            BLT:     b.taken = ($signed(x) < $signed(y));
            default: b.taken = ($signed(x) >= $signed(y));
        endcase
        return b;
    endfunction

    function automatic int expected_latency(alu_op_t op);
        if (op inside {MUL, MULH, MULHU}) begin
            return MUL_LATENCY + 1;
        end
        return is_muldiv_op(op) ? 34 : 2;
    endfunction

    task automatic report_fail(input int kind, input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        err_count[kind]++;
    endtask

    task automatic record_dispatch(input dispatch_t d);
        exp_commit[d.uuid] = expected_commit(d);
        pending[d.uuid]    = 1'b1;
        disp_cycle[d.uuid] = cycle;
        exp_lat[d.uuid]    = timed ? expected_latency(d.op) : 0;
        outstanding++;
        if (d.op inside {BEQ, BNE, BLT, BGE}) begin
            exp_branch.push_back(expected_branch(d));
        end
    endtask

    task automatic check_commit(input commit_t c);
        assert (pending[c.uuid])
            else report_fail(0, $sformatf("commit of uuid %0d which is not outstanding", c.uuid));
        if (pending[c.uuid]) begin
            assert (c == exp_commit[c.uuid])
                else report_fail(0, $sformatf("uuid %0d commit %h, expected %h",
                                              c.uuid, c, exp_commit[c.uuid]));
            if (exp_lat[c.uuid] != 0) begin
                assert (cycle - disp_cycle[c.uuid] == exp_lat[c.uuid])
                    else report_fail(1, $sformatf("uuid %0d took %0d cycles, expected %0d",
                                                  c.uuid, cycle - disp_cycle[c.uuid],
                                                  exp_lat[c.uuid]));
            end
            pending[c.uuid] = 1'b0;
            outstanding--;
            n_commits++;
        end
    endtask

    task automatic check_branch(input branch_ctl_t b);
        branch_ctl_t exp;
        assert (exp_branch.size() > 0)
            else report_fail(2, "branch_ctl pulse with no branch outstanding");
        if (exp_branch.size() > 0) begin
            exp = exp_branch.pop_front();
            assert (b == exp)
                else report_fail(2, $sformatf("branch_ctl %h, expected %h", b, exp));
            n_branches++;
        end
    endtask

    // Monitor samples before the DUT registers update on this edge
    always @(posedge clk) begin
        cycle++;
        if (!rst && dispatch_valid && dispatch_ready) begin
            record_dispatch(dispatch);
        end
        if (!rst && commit_valid && commit_ready) begin
            check_commit(commit);
        end
        if (!rst && branch_ctl_valid) begin
            check_branch(branch_ctl);
        end
    end

    task automatic step_negedge();
        @(negedge clk);
        commit_ready = bp_on ? ({$random(seed)} % 10 >= 3) : 1'b1;
    endtask

    task automatic idle_cycle();
        step_negedge();
        dispatch_valid = 1'b0;
    endtask

    task automatic send_op(input dispatch_t d);
        step_negedge();
        dispatch       = d;
        dispatch_valid = 1'b1;
        @(posedge clk);
        while (!dispatch_ready) begin
            step_negedge();
            @(posedge clk);
        end
    endtask

    task automatic random_op(input alu_op_t op, output dispatch_t d);
        d.uuid = next_uuid;
        next_uuid++;
        d.wid = warp_id_t'($random(seed));
        do begin
            d.tmask = tmask_t'($random(seed));
        end while (d.tmask == '0);
        d.pc  = word_t'($random(seed)) & ~32'h3;
        d.op  = op;
        d.rd  = reg_id_t'($random(seed));
        d.wb  = 1'($random(seed));
        d.imm = word_t'($random(seed));
        for (int i = 0; i < NUM_LANES; i++) begin
            d.rs1_data[i] = rand_word();
            d.rs2_data[i] = rand_word();
        end
    endtask

    // Overflow, division by zero and shift amounts of 32 and above
    task automatic apply_corner(inout dispatch_t d);
        d.tmask       = '1;
        d.rs1_data[0] = MIN_INT;
        d.rs2_data[0] = '1;
        d.rs1_data[1] = 32'hffff_fff9;
        d.rs2_data[1] = '0;
        d.rs1_data[2] = 32'h1234_5678;
        d.rs2_data[2] = 32'd35;
        d.rs1_data[3] = '1;
        d.rs2_data[3] = 32'd32;
    endtask

    task automatic run_isolated(input dispatch_t d);
        send_op(d);
        idle_cycle();
        while (pending[d.uuid]) begin
            idle_cycle();
        end
    endtask

    task automatic finish_run();
        int    total;
        int    proto_errs;
        string counts;
        for (int u = 0; u < 256; u++) begin
            if (pending[u]) begin
                $display("uuid %0d was dispatched but never committed", u);
                err_count[3]++;
            end
        end
        if (exp_branch.size() != 0) begin
            $display("%0d branches never produced a branch_ctl pulse", exp_branch.size());
            err_count[3] += exp_branch.size();
        end
        proto_errs = alu_unit_inst.alu_unit_asserts_inst.fail_count;
        total      = err_count[0] + err_count[1] + err_count[2] + err_count[3] + proto_errs;
        counts     = $sformatf("data=%0d latency=%0d branch=%0d missing=%0d protocol=%0d",
                               err_count[0], err_count[1], err_count[2], err_count[3],
                               proto_errs);
        $display("Summary: %0d commits, %0d branch pulses, errors %s",
                 n_commits, n_branches, counts);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        #(MAX_OPS * CYCLES_PER_OP * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns",
                 MAX_OPS * CYCLES_PER_OP * CLK_PERIOD);
        $display("Regression failed");
        $finish;
    end

    initial begin
        dispatch_t d;
        seed           = 63012;
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        commit_ready   = 1'b1;
        timed          = 1'b0;
        bp_on          = 1'b0;
        next_uuid      = '0;
        cycle          = 0;
        outstanding    = 0;
        n_commits      = 0;
        n_branches     = 0;
        pending        = '0;
        err_count      = '{default: 0};
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // One op at a time so that the latency of each class can be checked
        timed = 1'b1;
        for (int k = 0; k < NUM_OPCODES; k++) begin
            random_op(alu_op_t'(k), d);
            run_isolated(d);
            random_op(alu_op_t'(k), d);
            apply_corner(d);
            run_isolated(d);
        end

        // Mixed traffic under random back-pressure
        timed = 1'b0;
        bp_on = 1'b1;
        repeat (RANDOM_OPS) begin
            random_op(alu_op_t'({$random(seed)} % NUM_OPCODES), d);
            send_op(d);
            if ({$random(seed)} % 4 == 0) begin
                idle_cycle();
            end
        end
        idle_cycle();
        bp_on = 1'b0;
        while (outstanding != 0) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();
        finish_run();
    end

endmodule

// File: tb.f
source/alu_pkg.sv
source/int_unit.sv
source/muldiv_unit.sv
source/commit_arb.sv
source/alu_unit.sv
test/alu_unit_asserts.sv
test/alu_unit_tb.sv
